// File: run_sim.sh
#!/bin/sh
# build and run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sid_filter -f sim.f -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error"

[ -f sim.log ] && cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log 2>/dev/null \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation did not pass, see build.log and sim.log"; exit 1; }

// File: sid_filter_top.sv
module sid_filter_top (
    input  logic             clk,
    input  logic             rst,
    input  logic [10:0]      fc,
    input  logic [7:0]       res_filt,
    input  logic [7:0]       mode_vol,
    input  sid_pkg::sample_t voice1,
    input  sid_pkg::sample_t voice2,
    input  sid_pkg::sample_t voice3,
    input  sid_pkg::sample_t ext_in,
    input  logic             input_valid,
    input  logic             enable,
    input  logic [1:0]       mixctl,
    output sid_pkg::sample_t sound
);
    import sid_pkg::*;

    sample_t vi;   // filter input sum
    sample_t vnf;  // bypass sum
    sample_t vf;   // selected filter outputs

    sid_frame_if frm ();

    sid_frame_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .input_valid (input_valid),
        .fc          (fc),
        .res_filt    (res_filt),
        .mode_vol    (mode_vol),
        .mixctl      (mixctl),
        .enable      (enable),
        .frm         (frm.ctrl)
    );

    sid_voice_router u_router (
        .clk    (clk),
        .rst    (rst),
        .voice1 (voice1),
        .voice2 (voice2),
        .voice3 (voice3),
        .ext_in (ext_in),
        .frm    (frm.router),
        .vi     (vi),
        .vnf    (vnf)
    );

    sid_svf u_svf (
        .clk (clk),
        .rst (rst),
        .frm (frm.svf),
        .vi  (vi),
        .vf  (vf)
    );

    sid_output_mix u_mix (
        .clk   (clk),
        .rst   (rst),
        .frm   (frm.mix),
        .vnf   (vnf),
        .vi    (vi),
        .vf    (vf),
        .sound (sound)
    );

endmodule

// File: sid_frame_ctrl.sv
module sid_frame_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        input_valid,
    input  logic [10:0] fc,
    input  logic [7:0]  res_filt,
    input  logic [7:0]  mode_vol,
    input  logic [1:0]  mixctl,
    input  logic        enable,
    sid_frame_if.ctrl   frm
);
    import sid_pkg::*;

    step_t      step;
    logic       accept;
    logic [35:0] fc_prod;
    coef_t      w0_r;
    coef_t      q_r;
    logic [3:0] res_route_r;
    logic [2:0] filt_sel_r;
    logic       voice3_off_r;
    logic [3:0] volume_r;
    logic [1:0] mixctl_r;
    logic       filt_en_r;

    assign accept = (step == '0) && input_valid;

    // linear cutoff curve
    assign fc_prod = FC_SCALE * ({25'd0, fc} + 36'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (step == '0) begin
            if (input_valid) step <= 4'd1;  // otherwise wait in step 0
        end else if (step == LAST_STEP) begin
            step <= '0;
        end else begin
            step <= step + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            w0_r         <= '0;
            q_r          <= '0;
            res_route_r  <= '0;
            filt_sel_r   <= '0;
            voice3_off_r <= 1'b0;
            volume_r     <= '0;
            mixctl_r     <= '0;
            filt_en_r    <= 1'b0;
        end else if (accept) begin
            w0_r         <= coef_t'({fc_prod[35], fc_prod[28:12]});
            q_r          <= coef_t'({7'd0, Q_TABLE[res_filt[7:4]]});
            res_route_r  <= res_filt[3:0];
            filt_sel_r   <= mode_vol[6:4];
            voice3_off_r <= mode_vol[7];
            volume_r     <= mode_vol[3:0];
            mixctl_r     <= mixctl;
            filt_en_r    <= enable;
        end
    end

    assign frm.step       = step;
    assign frm.accept     = accept;
    assign frm.w0         = w0_r;
    assign frm.q          = q_r;
    assign frm.res_route  = res_route_r;
    assign frm.filt_sel   = filt_sel_r;
    assign frm.voice3_off = voice3_off_r;
    assign frm.volume     = volume_r;
    assign frm.mixctl     = mixctl_r;
    assign frm.filt_en    = filt_en_r;

endmodule

// File: sid_frame_if.sv
interface sid_frame_if;
    import sid_pkg::*;

    step_t      step;
    logic       accept;     // high in the step 0 cycle that starts a frame
    coef_t      w0;
    coef_t      q;
    logic [3:0] res_route;  // voice1, voice2, voice3, ext_in
    logic [2:0] filt_sel;   // hp, bp, lp
    logic       voice3_off;
    logic [3:0] volume;
    logic [1:0] mixctl;
    logic       filt_en;

    modport ctrl (
        output step, accept, w0, q, res_route, filt_sel,
        output voice3_off, volume, mixctl, filt_en
    );

    modport router (input step, accept, res_route, voice3_off);

    modport svf (input step, accept, w0, q, filt_sel);

    modport mix (input step, accept, volume, mixctl, filt_en);

endinterface

// File: sid_output_mix.sv
module sid_output_mix (
    input  logic             clk,
    input  logic             rst,
    sid_frame_if.mix         frm,
    input  sid_pkg::sample_t vnf,
    input  sid_pkg::sample_t vi,
    input  sid_pkg::sample_t vf,
    output sid_pkg::sample_t sound
);
    import sid_pkg::*;

    sample_t            mix;
    sample_t            byp_op;
    sample_t            filt_op;
    logic signed [21:0] prod;  // 18b x 4b volume fits in 22b

    assign byp_op  = frm.mixctl[1] ? '0 : vnf;
    assign filt_op = !frm.filt_en ? vi : (frm.mixctl[0] ? '0 : vf);

    always_ff @(posedge clk) begin
        if (frm.step == 4'd9) mix <= add_sat(byp_op, filt_op);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod  <= '0;
            sound <= '0;
        end else begin
            if (frm.step == 4'd10) prod <= mix * $signed({1'b0, frm.volume});
            // divide by 8, clamp to 18 bits
            if (frm.accept) begin
                if (prod[21] ^ prod[20]) sound <= sample_t'({prod[21], {17{prod[20]}}});
                else                     sound <= sample_t'(prod[20:3]);
            end
        end
    end

endmodule

// File: sid_pkg.sv
package sid_pkg;

    localparam int SAMPLE_W = 18;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SAMPLE_W-1:0] coef_t;   // w0 and q
    typedef logic [3:0] step_t;

    localparam step_t LAST_STEP = 4'd10;          // frame is 11 cycles
    localparam sample_t VNF_BIAS = 18'sd16384;    // bypass sum start value
    localparam logic [17:0] FC_SCALE = 18'd82355;

    // resonance divisors, indexed by res_filt[7:4]
    localparam logic [10:0] Q_TABLE [16] = '{
        11'd1448, 11'd1328, 11'd1218, 11'd1117,
        11'd1024, 11'd939,  11'd861,  11'd790,
        11'd724,  11'd664,  11'd609,  11'd558,
        11'd512,  11'd470,  11'd431,  11'd395
    };

    // 18-bit signed add, clamps on overflow
    function automatic sample_t add_sat(sample_t a, sample_t b);
        logic [SAMPLE_W:0] tmp;
        tmp = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
        if (tmp[SAMPLE_W] ^ tmp[SAMPLE_W-1]) begin
            return sample_t'({tmp[SAMPLE_W], {(SAMPLE_W-1){tmp[SAMPLE_W-1]}}});
        end
        return sample_t'(tmp[SAMPLE_W-1:0]);
    endfunction

    function automatic sample_t sub_sat(sample_t a, sample_t b);
        logic [SAMPLE_W:0] tmp;
        tmp = {a[SAMPLE_W-1], a} - {b[SAMPLE_W-1], b};
        if (tmp[SAMPLE_W] ^ tmp[SAMPLE_W-1]) begin
            return sample_t'({tmp[SAMPLE_W], {(SAMPLE_W-1){tmp[SAMPLE_W-1]}}});
        end
        return sample_t'(tmp[SAMPLE_W-1:0]);
    endfunction

endpackage

// File: sid_svf.sv
module sid_svf (
    input  logic             clk,
    input  logic             rst,
    sid_frame_if.svf         frm,
    input  sid_pkg::sample_t vi,
    output sid_pkg::sample_t vf
);
    import sid_pkg::*;

    sample_t vhp;
    sample_t vbp;
    sample_t vlp;
    sample_t dvbp;
    sample_t dvlp;

    logic signed [35:0] mul_hp;
    logic signed [35:0] mul_bp;
    logic signed [35:0] mul_q;

    assign mul_hp = frm.w0 * vhp;
    assign mul_bp = frm.w0 * vbp;
    assign mul_q  = frm.q * vbp;

    always_ff @(posedge clk) begin
        if (rst) begin
            vhp  <= '0;
            vbp  <= '0;
            vlp  <= '0;
            dvbp <= '0;
            dvlp <= '0;
            vf   <= '0;
        end else if (frm.accept) begin
            vf <= '0;  // state carries over, only the output sum restarts
        end else begin
            case (frm.step)
                4'd3: begin
                    dvbp <= sample_t'({mul_hp[35], mul_hp[35:19]});
                end
                4'd4: begin
                    dvlp <= sample_t'({mul_bp[35], mul_bp[35:19]});  // old vbp
                    vbp  <= sub_sat(vbp, dvbp);
                end
                4'd5: begin
                    if (frm.filt_sel[1]) vf <= add_sat(vf, vbp);
                    vlp <= sub_sat(vlp, dvlp);
                end
                4'd6: begin
                    if (frm.filt_sel[0]) vf <= add_sat(vf, vlp);
                    // q scaled by 1/1024
                    vhp <= sub_sat(sample_t'({mul_q[35], mul_q[26:10]}), vlp);
                end
                4'd7: begin
                    vhp <= sub_sat(vhp, vi);
                end
                4'd8: begin
                    if (frm.filt_sel[2]) vf <= add_sat(vf, vhp);
                end
                default: ;
            endcase
        end
    end

endmodule

// File: sid_voice_router.sv
module sid_voice_router (
    input  logic             clk,
    input  logic             rst,
    input  sid_pkg::sample_t voice1,
    input  sid_pkg::sample_t voice2,
    input  sid_pkg::sample_t voice3,
    input  sid_pkg::sample_t ext_in,
    sid_frame_if.router      frm,
    output sid_pkg::sample_t vi,
    output sid_pkg::sample_t vnf
);
    import sid_pkg::*;

    sample_t src;
    logic    src_en;
    logic    to_filter;
    logic    drop;

    // one source per step, 1 to 4
    always_comb begin
        src       = '0;
        src_en    = 1'b0;
        to_filter = 1'b0;
        drop      = 1'b0;
        case (frm.step)
            4'd1: begin
                src       = voice1;
                src_en    = 1'b1;
                to_filter = frm.res_route[0];
            end
            4'd2: begin
                src       = voice2;
                src_en    = 1'b1;
                to_filter = frm.res_route[1];
            end
            4'd3: begin
                src       = voice3;
                src_en    = 1'b1;
                to_filter = frm.res_route[2];
                drop      = frm.voice3_off;  // only matters when unrouted
            end
            4'd4: begin
                src       = ext_in;
                src_en    = 1'b1;
                to_filter = frm.res_route[3];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || frm.accept) begin
            vi  <= '0;
            vnf <= VNF_BIAS;
        end else if (src_en) begin
            if (to_filter) vi <= add_sat(vi, src);
            else if (!drop) vnf <= add_sat(vnf, src);
        end
    end

endmodule

// File: sim.f
sid_pkg.sv
sid_frame_if.sv
sid_frame_ctrl.sv
sid_voice_router.sv
sid_svf.sv
sid_output_mix.sv
sid_filter_top.sv
tb_sid_filter.sv

// File: tb_sid_filter.sv
module tb_sid_filter;
    timeunit 1ns;
    timeprecision 1ps;

    import sid_pkg::*;

    localparam int N_TESTS = 10;

    typedef struct packed {
        int          v1;
        int          v2;
        int          v3;
        int          ext;
        logic [10:0] fc;
        logic [7:0]  res_filt;
        logic [7:0]  mode_vol;
        logic [1:0]  mixctl;
        logic        en;
        logic [1:0]  rnd;     // bit 0 voices, bit 1 volume
        logic        settle;  // lowpass test, checked on its last frame
        int          frames;
        int          tol;     // percent
    } test_t;

    logic        clk;
    logic        rst;
    logic [10:0] fc;
    logic [7:0]  res_filt;
    logic [7:0]  mode_vol;
    sample_t     voice1;
    sample_t     voice2;
    sample_t     voice3;
    sample_t     ext_in;
    logic        input_valid;
    logic        enable;
    logic [1:0]  mixctl;
    sample_t     sound;

    test_t       tests [N_TESTS];
    string       test_name [N_TESTS];
    int          total_frames = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    logic [15:0] lfsr = 16'd48550;

    sid_filter_top uut (
        .clk         (clk),
        .rst         (rst),
        .fc          (fc),
        .res_filt    (res_filt),
        .mode_vol    (mode_vol),
        .voice1      (voice1),
        .voice2      (voice2),
        .voice3      (voice3),
        .ext_in      (ext_in),
        .input_valid (input_valid),
        .enable      (enable),
        .mixctl      (mixctl),
        .sound       (sound)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output int r);
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int clamp18(int x);
        if (x > 131071) return 131071;
        if (x < -131072) return -131072;
        return x;
    endfunction

    // router and output rules, vf taken as 0 or as the settled lowpass
    function automatic int expected_sound(int v1, int v2, int v3, int ext, logic [7:0] rf,
                                          logic [7:0] mv, logic [1:0] mc, logic en, bit lp);
        int src [4];
        int sum_i;
        int sum_nf;
        int vf;
        int mix;
        src[0] = v1;
        src[1] = v2;
        src[2] = v3;
        src[3] = ext;
        sum_i  = 0;
        sum_nf = int'(VNF_BIAS);
        for (int i = 0; i < 4; i++) begin
            if (rf[i]) sum_i = clamp18(sum_i + src[i]);
            else if (!(i == 2 && mv[7])) sum_nf = clamp18(sum_nf + src[i]);
        end
        vf  = lp ? clamp18(-sum_i) : 0;  // lowpass ends at -vi
        mix = clamp18((mc[1] ? 0 : sum_nf) + (!en ? sum_i : (mc[0] ? 0 : vf)));
        return clamp18((mix * int'(mv[3:0])) >>> 3);
    endfunction

    task automatic check_value(input int got, input int exp, input int tol_pct, input string what);
        int diff;
        int lim;
        diff = (got > exp) ? got - exp : exp - got;
        lim  = ((exp < 0) ? -exp : exp) * tol_pct / 100;
        checks++;
        test_checks++;
        if (diff > lim) begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic fill_table();
        // v1, v2, v3, ext, fc, res_filt, mode_vol, mixctl, en, rnd, settle, frames, tol
        tests[0] = '{0, 0, 0, 0, 11'd0, 8'h00, 8'h00, 2'b00, 1'b0, 2'b00, 1'b0, 3, 0};
        tests[1] = '{0, 0, 0, 0, 11'd0, 8'h00, 8'h00, 2'b00, 1'b0, 2'b01, 1'b0, 6, 0};
        tests[2] = '{0, 0, 0, 0, 11'd0, 8'h00, 8'h00, 2'b00, 1'b0, 2'b11, 1'b0, 20, 0};
        tests[3] = '{1000, 2000, 30000, -500, 11'd0, 8'h00, 8'h88, 2'b00, 1'b0, 2'b00, 1'b0,
                     3, 0};
        tests[4] = '{5000, 2000, 3000, 4000, 11'd0, 8'h01, 8'h08, 2'b10, 1'b0, 2'b00, 1'b0,
                     3, 0};
        tests[5] = '{7000, -3000, 2500, 1200, 11'd0, 8'h03, 8'h0c, 2'b00, 1'b1, 2'b00, 1'b0,
                     3, 0};
        tests[6] = '{7000, -3000, 2500, 1200, 11'd0, 8'h03, 8'h0c, 2'b00, 1'b0, 2'b00, 1'b0,
                     3, 0};
        tests[7] = '{20000, 0, 0, 0, 11'd2047, 8'h01, 8'h18, 2'b00, 1'b1, 2'b00, 1'b1, 400, 2};
        tests[8] = '{100000, 100000, 100000, 100000, 11'd0, 8'h00, 8'h0f, 2'b00, 1'b0, 2'b00,
                     1'b0, 3, 0};
        tests[9] = '{-100000, -100000, -100000, -100000, 11'd0, 8'h00, 8'h0f, 2'b00, 1'b0,
                     2'b00, 1'b0, 3, 0};
        test_name = '{"idle", "vol_zero", "bypass_rand", "voice3_mute", "bypass_zero",
                      "route_en", "route_dis", "lowpass", "sat_pos", "sat_neg"};
        for (int i = 0; i < N_TESTS; i++) total_frames += tests[i].frames;
    endtask

    initial begin : watchdog
        int limit;
        wait (total_frames > 0);
        limit = total_frames * 11 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        test_t      t;
        int         v [4];
        int         r;
        logic [7:0] mv;
        int         prev_exp;
        bit         prev_ok;
        int         frame_no;
        string      label;

        clk         = 1'b0;
        rst         = 1'b1;
        fc          = '0;
        res_filt    = '0;
        mode_vol    = '0;
        voice1      = '0;
        voice2      = '0;
        voice3      = '0;
        ext_in      = '0;
        input_valid = 1'b0;
        enable      = 1'b0;
        mixctl      = '0;
        fill_table();
        prev_exp = 0;  // product register starts at 0
        prev_ok  = 1'b1;
        frame_no = 0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value(int'(sound), 0, 0, "sound after reset");
        @(posedge clk);

        for (int ti = 0; ti < N_TESTS; ti++) begin
            t           = tests[ti];
            test_checks = 0;
            test_errors = 0;
            for (int f = 0; f < t.frames; f++) begin
                v[0] = t.v1;
                v[1] = t.v2;
                v[2] = t.v3;
                v[3] = t.ext;
                mv   = t.mode_vol;
                if (t.rnd[0]) begin
                    for (int i = 0; i < 4; i++) begin
                        take_bits(16, r);
                        v[i] = (r >= 32768) ? r - 65536 : r;
                    end
                end
                if (t.rnd[1]) begin
                    take_bits(4, r);
                    mv[3:0] = r[3:0];
                end
                // step is 10 here, next edge accepts the frame
                voice1      <= sample_t'(v[0]);
                voice2      <= sample_t'(v[1]);
                voice3      <= sample_t'(v[2]);
                ext_in      <= sample_t'(v[3]);
                fc          <= t.fc;
                res_filt    <= t.res_filt;
                mode_vol    <= mv;
                mixctl      <= t.mixctl;
                enable      <= t.en;
                input_valid <= 1'b1;
                @(posedge clk);
                @(negedge clk);
                label = $sformatf("%s, sound at frame %0d", test_name[ti], frame_no);
                if (prev_ok) check_value(int'(sound), prev_exp, 0, label);
                if (t.settle && f == t.frames - 1) begin
                    check_value(int'(sound), expected_sound(v[0], v[1], v[2], v[3],
                                t.res_filt, mv, t.mixctl, t.en, 1'b1), t.tol, label);
                end
                prev_exp = expected_sound(v[0], v[1], v[2], v[3], t.res_filt, mv, t.mixctl,
                                          t.en, 1'b0);
                prev_ok  = !t.settle;
                frame_no++;
                repeat (10) @(posedge clk);
            end
            $display("test %0d %s: %0d frames, %0d checks, %0d errors", ti, test_name[ti],
                     t.frames, test_checks, test_errors);
        end

        // last frame shows up at the next acceptance
        @(posedge clk);
        @(negedge clk);
        if (prev_ok) check_value(int'(sound), prev_exp, 0, "sound of the final frame");

        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
